/* hw/ctrl_pkg.sv */
/*
 * shared definitions for the pipeline controller
 * width constants, PC / operand / jump select encodings, FSM states
 * packed structs for register hits, write enables, debug and exception
 */

package ctrl_pkg;

  //////////////////////
  // widths
  //////////////////////

  // operands tracked per instruction (A, B, C)
  localparam int unsigned MAX_OPS    = 3;
  // register file address width
  localparam int unsigned REG_ADDR_W = 5;

  //////////////////////
  // encodings
  //////////////////////

  // fetch unit PC source
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101,
    PC_DBG_NPC   = 3'b111
  } pc_mux_e;

  // operand source in ID
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

  // jump kind reported by the decoder
  typedef enum logic [1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    BRANCH_COND = 2'b11
  } jump_e;

  // controller FSM states
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH_EX,
    FLUSH_WB,
    DBG_SIGNAL,
    DBG_SIGNAL_SLEEP,
    DBG_WAIT,
    DBG_WAIT_BRANCH,
    DBG_WAIT_SLEEP
  } ctrl_state_e;

  //////////////////////
  // structs
  //////////////////////

  // bit 0 is operand A, bit 1 operand B, bit 2 operand C
  // a set bit means the destination (REG_ADDR_W wide) matches that source
  typedef struct packed {
    logic [MAX_OPS-1:0] ex_hit;
    logic [MAX_OPS-1:0] wb_hit;
    logic [MAX_OPS-1:0] alu_hit;
  } reg_hit_t;

  // pending register writes per stage
  typedef struct packed {
    logic we_ex;
    logic we_wb;
    logic we_alu;
  } reg_we_t;

  // debugger requests
  typedef struct packed {
    logic req;
    logic stall;
    logic jump_req;
  } dbg_req_t;

  // exception controller strobes
  typedef struct packed {
    logic ack;
    logic save_if;
    logic save_id;
    logic restore_id;
  } exc_ctrl_t;

  typedef struct packed {
    logic halt_if;
    logic halt_id;
  } halt_t;

  // one operand select per tracked operand, index 0 is operand A
  typedef fw_sel_e [MAX_OPS-1:0] fw_sel_vec_t;

endpackage

/* hw/ctrl_fsm.sv */
/*
 * main controller FSM
 * reset / boot / sleep, decode with jump, branch, exception and eret redirects,
 * pipeline flush for WFI, debug halt and resume
 */

`timescale 1ns/100ps

module ctrl_fsm (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 fetch_enable_i,
  input  logic                 instr_valid_i,
  input  logic                 id_ready_i,
  input  logic                 ex_valid_i,

  // decoder
  input  logic                 eret_insn_i,
  input  logic                 pipe_flush_i,
  input  logic                 branch_taken_ex_i,
  input  ctrl_pkg::jump_e      jump_in_dec_i,
  input  ctrl_pkg::jump_e      jump_in_id_i,

  input  logic                 data_load_event_i,
  input  logic                 exc_req_i,
  input  ctrl_pkg::dbg_req_t   dbg_i,
  input  logic                 jr_stall_i,

  output logic                 instr_req_o,
  output logic                 ctrl_busy_o,
  output logic                 is_decoding_o,
  output logic                 pc_set_o,
  output ctrl_pkg::pc_mux_e    pc_mux_o,
  output ctrl_pkg::exc_ctrl_t  exc_o,
  output ctrl_pkg::halt_t      halt_o,
  output logic                 dbg_ack_o
);

  import ctrl_pkg::*;

  ctrl_state_e state_q, state_n;

  // jump guard, one redirect strobe per instruction in ID
  logic jump_done, jump_done_q;

  //////////////////////
  // next state / outputs
  //////////////////////

  always_comb
  begin
    instr_req_o   = 1'b1;
    ctrl_busy_o   = 1'b1;
    is_decoding_o = 1'b0;
    pc_set_o      = 1'b0;
    pc_mux_o      = PC_BOOT;
    exc_o         = '0;
    halt_o        = '0;
    dbg_ack_o     = 1'b0;
    jump_done     = jump_done_q;
    state_n       = state_q;

    unique case (state_q)
      RESET:
      begin
        // idle until the core is enabled
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        if (fetch_enable_i)
          state_n = BOOT_SET;
        else if (dbg_i.req)
          // debugger may attach before boot, NPC is not set yet
          state_n = DBG_SIGNAL;
      end

      BOOT_SET:
      begin
        // load boot address into the fetch unit
        pc_mux_o = PC_BOOT;
        pc_set_o = 1'b1;
        state_n  = FIRST_FETCH;
      end

      SLEEP:
      begin
        instr_req_o    = 1'b0;
        ctrl_busy_o    = 1'b0;
        halt_o.halt_if = 1'b1;
        halt_o.halt_id = 1'b1;
        // wake on enable or pending exception
        if (dbg_i.req)
          state_n = (fetch_enable_i || exc_req_i) ? DBG_SIGNAL : DBG_SIGNAL_SLEEP;
        else if (fetch_enable_i || exc_req_i)
          state_n = FIRST_FETCH;
      end

      FIRST_FETCH:
      begin
        // wait for the first instruction to reach ID
        if (id_ready_i && !dbg_i.stall)
          state_n = DECODE;
        // exception that woke us from sleep, pipeline is already empty
        if (exc_req_i)
        begin
          pc_mux_o      = PC_EXCEPTION;
          pc_set_o      = 1'b1;
          exc_o.ack     = 1'b1;
          exc_o.save_if = 1'b1;
        end
      end

      DECODE:
      begin
        // a taken branch in EX kills the instruction in ID
        if (instr_valid_i && !branch_taken_ex_i)
        begin
          is_decoding_o = 1'b1;

          if (jump_in_dec_i == BRANCH_JAL || jump_in_dec_i == BRANCH_JALR)
          begin
            // target known in ID, redirect once jr hazard is gone
            pc_mux_o = PC_JUMP;
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_set_o  = 1'b1;
              jump_done = 1'b1;
            end
          end
          else if (exc_req_i)
          begin
            pc_mux_o       = PC_EXCEPTION;
            pc_set_o       = 1'b1;
            exc_o.ack      = 1'b1;
            exc_o.save_id  = 1'b1;
            // keep the ID instruction out of EX
            halt_o.halt_id = 1'b1;
          end

          if (eret_insn_i)
          begin
            pc_mux_o         = PC_ERET;
            exc_o.restore_id = 1'b1;
            if (!jump_done_q)
            begin
              pc_set_o  = 1'b1;
              jump_done = 1'b1;
            end
          end

          // WFI, or eret back into sleep, drains the pipeline
          if (pipe_flush_i || (eret_insn_i && !fetch_enable_i))
          begin
            halt_o.halt_if = 1'b1;
            halt_o.halt_id = 1'b1;
            state_n        = FLUSH_EX;
          end
          else if (dbg_i.req)
          begin
            halt_o.halt_if = 1'b1;
            // leave only once the ID instruction has moved on
            if (id_ready_i)
              state_n = (jump_in_id_i == BRANCH_COND) ? DBG_WAIT_BRANCH : DBG_SIGNAL;
            else if (data_load_event_i)
              // load event sits in EX and blocks ID
              state_n = DBG_SIGNAL;
          end
        end

        if (branch_taken_ex_i)
        begin
          pc_mux_o      = PC_BRANCH;
          pc_set_o      = 1'b1;
          is_decoding_o = 1'b0;
          if (dbg_i.req)
            state_n = DBG_SIGNAL;
        end
      end

      DBG_WAIT_BRANCH:
      begin
        // branch from ID resolves in EX this cycle
        halt_o.halt_if = 1'b1;
        if (branch_taken_ex_i)
        begin
          pc_mux_o = PC_BRANCH;
          pc_set_o = 1'b1;
        end
        state_n = DBG_SIGNAL;
      end

      DBG_SIGNAL:
      begin
        dbg_ack_o      = 1'b1;
        halt_o.halt_if = 1'b1;
        state_n        = DBG_WAIT;
      end

      DBG_SIGNAL_SLEEP:
      begin
        dbg_ack_o      = 1'b1;
        halt_o.halt_if = 1'b1;
        state_n        = DBG_WAIT_SLEEP;
      end

      DBG_WAIT:
      begin
        // debugger owns the core, may set a new NPC
        halt_o.halt_if = 1'b1;
        if (dbg_i.jump_req)
        begin
          pc_mux_o = PC_DBG_NPC;
          pc_set_o = 1'b1;
        end
        if (!dbg_i.stall)
          state_n = DECODE;
      end

      DBG_WAIT_SLEEP:
      begin
        halt_o.halt_if = 1'b1;
        // new NPC means the core resumes instead of sleeping
        if (dbg_i.jump_req)
        begin
          pc_mux_o = PC_DBG_NPC;
          pc_set_o = 1'b1;
          state_n  = DBG_WAIT;
        end
        if (!dbg_i.stall)
          state_n = SLEEP;
      end

      FLUSH_EX:
      begin
        // NOP into EX until the last instruction leaves
        halt_o.halt_if = 1'b1;
        halt_o.halt_id = 1'b1;
        if (ex_valid_i)
          state_n = FLUSH_WB;
      end

      FLUSH_WB:
      begin
        halt_o.halt_if = 1'b1;
        halt_o.halt_id = 1'b1;
        if (fetch_enable_i)
        begin
          if (dbg_i.req)
            state_n = DBG_SIGNAL;
          else
          begin
            halt_o.halt_if = 1'b0;
            state_n        = DECODE;
          end
        end
        else
          state_n = dbg_i.req ? DBG_SIGNAL_SLEEP : SLEEP;
      end

      default:
      begin
        instr_req_o = 1'b0;
        state_n     = RESET;
      end
    endcase
  end

  //////////////////////
  // registers
  //////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_n;
      // cleared as soon as ID accepts the next instruction
      jump_done_q <= jump_done & ~id_ready_i;
    end
  end

endmodule

/* hw/hazard_unit.sv */
/*
 * hazard detection for the ID stage
 * load-use stall, jump-register stall, write-enable deassert
 */

`timescale 1ns/100ps

module hazard_unit #(
  parameter int unsigned NUM_OPS = 3
) (
  input  logic                is_decoding_i,
  input  logic                illegal_insn_i,
  input  logic                data_req_ex_i,
  input  ctrl_pkg::jump_e     jump_in_dec_i,
  input  ctrl_pkg::reg_we_t   reg_we_i,
  input  ctrl_pkg::reg_hit_t  reg_hit_i,

  output logic                load_stall_o,
  output logic                jr_stall_o,
  output logic                deassert_we_o
);

  import ctrl_pkg::*;

  // operands this core actually reads
  localparam logic [MAX_OPS-1:0] OP_MASK = {MAX_OPS{1'b1}} >> (MAX_OPS - NUM_OPS);

  logic [MAX_OPS-1:0] ex_hit_used;
  logic               jr_dep;

  assign ex_hit_used = reg_hit_i.ex_hit & OP_MASK;

  // load in EX writing a register read in ID
  assign load_stall_o = data_req_ex_i & reg_we_i.we_ex & (|ex_hit_used);

  // JALR target (operand A) still being produced somewhere down the pipe
  assign jr_dep = (reg_we_i.we_ex  & reg_hit_i.ex_hit[0]) |
                  (reg_we_i.we_wb  & reg_hit_i.wb_hit[0]) |
                  (reg_we_i.we_alu & reg_hit_i.alu_hit[0]);

  assign jr_stall_o = (jump_in_dec_i == BRANCH_JALR) & jr_dep;

  // no writes from instructions that are not decoded or must wait
  assign deassert_we_o = ~is_decoding_i | illegal_insn_i | load_stall_o | jr_stall_o;

endmodule

/* hw/fwd_unit.sv */
/*
 * operand forwarding select for the ID stage
 * regfile by default, WB or EX/ALU forward on a hit, misaligned override
 */

`timescale 1ns/100ps

module fwd_unit #(
  parameter int unsigned NUM_OPS = 3
) (
  input  ctrl_pkg::reg_we_t     reg_we_i,
  input  ctrl_pkg::reg_hit_t    reg_hit_i,
  input  logic                  data_misaligned_i,

  output ctrl_pkg::fw_sel_vec_t fw_sel_o
);

  import ctrl_pkg::*;

  // hits on operands beyond NUM_OPS are ignored
  localparam logic [MAX_OPS-1:0] OP_MASK = {MAX_OPS{1'b1}} >> (MAX_OPS - NUM_OPS);

  always_comb
  begin
    for (int i = 0; i < MAX_OPS; i++)
    begin
      fw_sel_o[i] = SEL_REGFILE;
      if (OP_MASK[i])
      begin
        // WB result first, ALU result is younger and wins
        if (reg_we_i.we_wb && reg_hit_i.wb_hit[i])
          fw_sel_o[i] = SEL_FW_WB;
        if (reg_we_i.we_alu && reg_hit_i.alu_hit[i])
          fw_sel_o[i] = SEL_FW_EX;
      end
    end

    // second half of a misaligned access
    // address from EX on A, no offset from B
    if (data_misaligned_i)
    begin
      fw_sel_o[0] = SEL_FW_EX;
      fw_sel_o[1] = SEL_REGFILE;
    end
  end

endmodule

/* hw/ctrl_top.sv */
/*
 * controller top level
 * FSM plus hazard and forwarding units
 */

`timescale 1ns/100ps

module ctrl_top #(
  parameter int unsigned NUM_OPS = 3
) (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  fetch_enable_i,
  input  logic                  instr_valid_i,
  input  logic                  id_ready_i,
  input  logic                  ex_valid_i,

  // decoder
  input  logic                  illegal_insn_i,
  input  logic                  eret_insn_i,
  input  logic                  pipe_flush_i,
  input  logic                  branch_taken_ex_i,
  input  ctrl_pkg::jump_e       jump_in_dec_i,
  input  ctrl_pkg::jump_e       jump_in_id_i,

  // LSU
  input  logic                  data_req_ex_i,
  input  logic                  data_misaligned_i,
  input  logic                  data_load_event_i,

  input  logic                  exc_req_i,
  input  ctrl_pkg::dbg_req_t    dbg_i,

  // register dependencies
  input  ctrl_pkg::reg_we_t     reg_we_i,
  input  ctrl_pkg::reg_hit_t    reg_hit_i,

  output logic                  instr_req_o,
  output logic                  ctrl_busy_o,
  output logic                  is_decoding_o,
  output logic                  pc_set_o,
  output ctrl_pkg::pc_mux_e     pc_mux_o,
  output ctrl_pkg::exc_ctrl_t   exc_o,
  output ctrl_pkg::halt_t       halt_o,
  output logic                  dbg_ack_o,
  output logic                  load_stall_o,
  output logic                  jr_stall_o,
  output logic                  deassert_we_o,
  output ctrl_pkg::fw_sel_vec_t fw_sel_o
);

  // jr_stall_o feeds back into the FSM to hold off the jump redirect
  ctrl_fsm u_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .instr_valid_i     (instr_valid_i),
    .id_ready_i        (id_ready_i),
    .ex_valid_i        (ex_valid_i),
    .eret_insn_i       (eret_insn_i),
    .pipe_flush_i      (pipe_flush_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .jump_in_dec_i     (jump_in_dec_i),
    .jump_in_id_i      (jump_in_id_i),
    .data_load_event_i (data_load_event_i),
    .exc_req_i         (exc_req_i),
    .dbg_i             (dbg_i),
    .jr_stall_i        (jr_stall_o),
    .instr_req_o       (instr_req_o),
    .ctrl_busy_o       (ctrl_busy_o),
    .is_decoding_o     (is_decoding_o),
    .pc_set_o          (pc_set_o),
    .pc_mux_o          (pc_mux_o),
    .exc_o             (exc_o),
    .halt_o            (halt_o),
    .dbg_ack_o         (dbg_ack_o)
  );

  hazard_unit #(
    .NUM_OPS (NUM_OPS)
  ) u_hazard (
    .is_decoding_i  (is_decoding_o),
    .illegal_insn_i (illegal_insn_i),
    .data_req_ex_i  (data_req_ex_i),
    .jump_in_dec_i  (jump_in_dec_i),
    .reg_we_i       (reg_we_i),
    .reg_hit_i      (reg_hit_i),
    .load_stall_o   (load_stall_o),
    .jr_stall_o     (jr_stall_o),
    .deassert_we_o  (deassert_we_o)
  );

  fwd_unit #(
    .NUM_OPS (NUM_OPS)
  ) u_fwd (
    .reg_we_i          (reg_we_i),
    .reg_hit_i         (reg_hit_i),
    .data_misaligned_i (data_misaligned_i),
    .fw_sel_o          (fw_sel_o)
  );

endmodule

/* tests/ctrl_tb.sv */
/*
 * testbench for the pipeline controller top level
 * directed FSM vectors read from the tests data file
 * random hazard and forwarding phase against a reference model
 * per-test summary line and closing counts
 */

`timescale 1ns/100ps

module ctrl_tb;

  import ctrl_pkg::*;

  localparam int CLK_PERIOD  = 10;
  localparam int RST_CYCLES  = 8;
  localparam int RAND_CYCLES = 200;
  localparam int NCOL        = 27;
  localparam int RAND_ID     = 6;

  // one vector line, one 12-bit field per column
  typedef logic [NCOL-1:0][11:0] row_t;

  logic clk = 1'b0;
  logic rst_n;

  // DUT inputs
  logic        fetch_enable;
  logic        instr_valid;
  logic        id_ready;
  logic        ex_valid;
  logic        illegal_insn;
  logic        eret_insn;
  logic        pipe_flush;
  logic        branch_taken;
  jump_e       jump_in_dec;
  jump_e       jump_in_id;
  logic        data_req_ex;
  logic        data_misaligned;
  logic        data_load_event;
  logic        exc_req;
  dbg_req_t    dbg;
  reg_we_t     reg_we;
  reg_hit_t    reg_hit;

  // DUT outputs
  logic        instr_req_o;
  logic        ctrl_busy_o;
  logic        is_decoding_o;
  logic        pc_set_o;
  pc_mux_e     pc_mux_o;
  exc_ctrl_t   exc_o;
  halt_t       halt_o;
  logic        dbg_ack_o;
  logic        load_stall_o;
  logic        jr_stall_o;
  logic        deassert_we_o;
  fw_sel_vec_t fw_sel_o;

  row_t        rows[$];
  logic [31:0] f [NCOL];
  logic [31:0] rng_state;
  int          n_rows;
  int          err_count;
  int          tests_passed;
  int          tests_failed;

  always #(CLK_PERIOD / 2) clk = ~clk;

  ctrl_top #(
    .NUM_OPS (3)
  ) dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable),
    .instr_valid_i     (instr_valid),
    .id_ready_i        (id_ready),
    .ex_valid_i        (ex_valid),
    .illegal_insn_i    (illegal_insn),
    .eret_insn_i       (eret_insn),
    .pipe_flush_i      (pipe_flush),
    .branch_taken_ex_i (branch_taken),
    .jump_in_dec_i     (jump_in_dec),
    .jump_in_id_i      (jump_in_id),
    .data_req_ex_i     (data_req_ex),
    .data_misaligned_i (data_misaligned),
    .data_load_event_i (data_load_event),
    .exc_req_i         (exc_req),
    .dbg_i             (dbg),
    .reg_we_i          (reg_we),
    .reg_hit_i         (reg_hit),
    .instr_req_o       (instr_req_o),
    .ctrl_busy_o       (ctrl_busy_o),
    .is_decoding_o     (is_decoding_o),
    .pc_set_o          (pc_set_o),
    .pc_mux_o          (pc_mux_o),
    .exc_o             (exc_o),
    .halt_o            (halt_o),
    .dbg_ack_o         (dbg_ack_o),
    .load_stall_o      (load_stall_o),
    .jr_stall_o        (jr_stall_o),
    .deassert_we_o     (deassert_we_o),
    .fw_sel_o          (fw_sel_o)
  );

  //////////////////////
  // helpers
  //////////////////////

  task check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      $display("FAIL %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      err_count++;
    end
  endtask

  // 32-bit LCG
  // upper bits are the usable ones
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task idle_inputs();
    fetch_enable    = 1'b0;
    instr_valid     = 1'b0;
    id_ready        = 1'b0;
    ex_valid        = 1'b0;
    illegal_insn    = 1'b0;
    eret_insn       = 1'b0;
    pipe_flush      = 1'b0;
    branch_taken    = 1'b0;
    jump_in_dec     = BRANCH_NONE;
    jump_in_id      = BRANCH_NONE;
    data_req_ex     = 1'b0;
    data_misaligned = 1'b0;
    data_load_event = 1'b0;
    exc_req         = 1'b0;
    dbg             = '0;
    reg_we          = '0;
    reg_hit         = '0;
  endtask

  // comment lines start with #
  // every other line is one cycle
  task load_rows(output bit ok);
    int    fd;
    int    n;
    int    i;
    string line;
    row_t  r;
    ok = 1'b1;
    fd = $fopen("tests/ctrl_tests.txt", "r");
    if (fd == 0)
    begin
      $display("could not open tests/ctrl_tests.txt");
      ok = 1'b0;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.substr(0, 0) != "#")
        begin
          n = $sscanf(line, "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                      f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17],
                      f[18], f[19], f[20], f[21], f[22], f[23], f[24], f[25], f[26]);
          if (n != NCOL)
          begin
            $display("malformed vector line: %s", line);
            ok = 1'b0;
          end
          else
          begin
            for (i = 0; i < NCOL; i++)
              r[i] = f[i][11:0];
            rows.push_back(r);
          end
        end
      end
      $fclose(fd);
      if (ok && rows.size() == 0)
      begin
        $display("no vectors found in tests/ctrl_tests.txt");
        ok = 1'b0;
      end
    end
    n_rows = rows.size();
  endtask

  task drive_row(input row_t r);
    fetch_enable    = r[1][0];
    instr_valid     = r[2][0];
    id_ready        = r[3][0];
    ex_valid        = r[4][0];
    illegal_insn    = r[5][0];
    eret_insn       = r[6][0];
    pipe_flush      = r[7][0];
    branch_taken    = r[8][0];
    jump_in_dec     = jump_e'(r[9][1:0]);
    jump_in_id      = jump_e'(r[10][1:0]);
    data_req_ex     = r[11][0];
    data_misaligned = r[12][0];
    data_load_event = r[13][0];
    exc_req         = r[14][0];
    // {req, stall, jump_req}
    dbg             = dbg_req_t'(r[15][2:0]);
    // {we_ex, we_wb, we_alu}
    reg_we          = reg_we_t'(r[16][2:0]);
    reg_hit         = reg_hit_t'(r[17][8:0]);
  endtask

  task check_row(input row_t r, input int k);
    string tag;
    tag = $sformatf("test %0d line %0d", r[0], k);
    check_val(pc_set_o, r[18], {tag, " pc_set_o"});
    check_val(pc_mux_o, r[19], {tag, " pc_mux_o"});
    check_val(ctrl_busy_o, r[20], {tag, " ctrl_busy_o"});
    check_val(instr_req_o, r[21], {tag, " instr_req_o"});
    check_val(is_decoding_o, r[22], {tag, " is_decoding_o"});
    check_val(halt_o, r[23], {tag, " halt_o"});
    check_val(dbg_ack_o, r[24], {tag, " dbg_ack_o"});
    check_val(exc_o, r[25], {tag, " exc_o"});
    check_val(jr_stall_o, r[26], {tag, " jr_stall_o"});
  endtask

  task report_test(input int id, input int errs_before);
    if (err_count == errs_before)
    begin
      $display("test %0d done, no errors", id);
      tests_passed++;
    end
    else
    begin
      $display("test %0d done, %0d errors", id, err_count - errs_before);
      tests_failed++;
    end
  endtask

  //////////////////////
  // reference model
  //////////////////////

  // younger ALU result beats WB
  // no hit reads the regfile
  function automatic logic [1:0] op_src(input reg_we_t we, input reg_hit_t hit, input int op);
    if (we.we_alu && hit.alu_hit[op])
      return SEL_FW_EX;
    else if (we.we_wb && hit.wb_hit[op])
      return SEL_FW_WB;
    else
      return SEL_REGFILE;
  endfunction

  // FSM parked in decode
  // only hazard and forwarding inputs move
  task run_random();
    logic [31:0] r1;
    logic [31:0] r2;
    logic        exp_load;
    logic        exp_jr;
    logic        exp_deassert;
    logic [5:0]  exp_fw;
    int          k;
    string       tag;
    for (k = 0; k < RAND_CYCLES; k++)
    begin
      rng_state = lcg_step(rng_state);
      r1        = rng_state;
      rng_state = lcg_step(rng_state);
      r2        = rng_state;
      idle_inputs();
      fetch_enable    = 1'b1;
      id_ready        = 1'b1;
      reg_we          = reg_we_t'(r1[31:29]);
      reg_hit         = reg_hit_t'(r1[28:20]);
      data_misaligned = r1[19];
      data_req_ex     = r1[18];
      jump_in_dec     = jump_e'(r2[31:30]);
      instr_valid     = r2[29];
      illegal_insn    = r2[28];
      #1;
      exp_load = data_req_ex & reg_we.we_ex & (|reg_hit.ex_hit);
      exp_jr   = (jump_in_dec == BRANCH_JALR) &
                 ((reg_we.we_ex & reg_hit.ex_hit[0]) |
                  (reg_we.we_wb & reg_hit.wb_hit[0]) |
                  (reg_we.we_alu & reg_hit.alu_hit[0]));
      exp_deassert = ~instr_valid | illegal_insn | exp_load | exp_jr;
      // operand A at the low end
      exp_fw[5:4] = op_src(reg_we, reg_hit, 2);
      exp_fw[3:2] = data_misaligned ? SEL_REGFILE : op_src(reg_we, reg_hit, 1);
      exp_fw[1:0] = data_misaligned ? SEL_FW_EX : op_src(reg_we, reg_hit, 0);
      tag = $sformatf("random %0d", k);
      check_val(is_decoding_o, instr_valid, {tag, " is_decoding_o"});
      check_val(load_stall_o, exp_load, {tag, " load_stall_o"});
      check_val(jr_stall_o, exp_jr, {tag, " jr_stall_o"});
      check_val(deassert_we_o, exp_deassert, {tag, " deassert_we_o"});
      check_val(fw_sel_o, exp_fw, {tag, " fw_sel_o"});
      @(negedge clk);
    end
  endtask

  //////////////////////
  // main sequence
  //////////////////////

  initial
  begin
    bit load_ok;
    int errs_before;
    int cur_id;
    int k;
    rst_n        = 1'b0;
    err_count    = 0;
    tests_passed = 0;
    tests_failed = 0;
    rng_state    = 32'd71;
    idle_inputs();
    load_rows(load_ok);
    if (!load_ok)
      $display("Simulation FAILED");
    else
    begin
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n       = 1'b1;
      cur_id      = rows[0][0];
      errs_before = 0;
      // drive on the falling edge, sample 1 ns later
      for (k = 0; k < n_rows; k++)
      begin
        if (rows[k][0] != cur_id)
        begin
          report_test(cur_id, errs_before);
          cur_id      = rows[k][0];
          errs_before = err_count;
        end
        drive_row(rows[k]);
        #1;
        check_row(rows[k], k);
        @(negedge clk);
      end
      report_test(cur_id, errs_before);
      errs_before = err_count;
      run_random();
      report_test(RAND_ID, errs_before);
      $display("tests passed %0d, tests failed %0d, mismatches %0d",
               tests_passed, tests_failed, err_count);
      if (err_count == 0)
        $display("Simulation PASSED");
      else
        $display("Simulation FAILED");
    end
    $finish;
  end

  // run length follows the vector count
  initial
  begin
    wait (n_rows > 0);
    #((n_rows + RAND_CYCLES + 20) * CLK_PERIOD);
    $display("timeout: simulation did not finish");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* tests/ctrl_tests.txt */
# id fen iv idr exv ill eret wfi brt jdec jid dreq dmis dld exc dbg we hit, then expected
# pcset mux busy ireq isdec halt dack exc jrs; hex, dbg={req,stall,jmp}, we={ex,wb,alu}
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 000  0 0 0 0 0 0 0 0 0
1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 000  0 0 0 0 0 0 0 0 0
1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 000  1 0 1 1 0 0 0 0 0
1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 000  0 0 1 1 0 0 0 0 0
1 1 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 000  0 0 1 1 0 0 0 0 0
1 1 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 000  0 0 1 1 0 0 0 0 0
1 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 000  0 0 1 1 1 0 0 0 0
2 1 1 0 0 0 0 0 0 1 0 0 0 0 0 0 0 000  1 2 1 1 1 0 0 0 0
2 1 1 0 0 0 0 0 0 1 0 0 0 0 0 0 0 000  0 2 1 1 1 0 0 0 0
2 1 1 0 0 0 0 0 0 1 0 0 0 0 0 0 0 000  0 2 1 1 1 0 0 0 0
2 1 1 1 0 0 0 0 0 1 0 0 0 0 0 0 0 000  0 2 1 1 1 0 0 0 0
2 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 000  0 0 1 1 1 0 0 0 0
2 1 1 1 0 0 0 0 0 2 0 0 0 0 0 0 4 040  0 2 1 1 1 0 0 0 1
2 1 1 1 0 0 0 0 0 2 0 0 0 0 0 0 0 040  1 2 1 1 1 0 0 0 0
2 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 000  0 0 1 1 1 0 0 0 0
3 1 1 1 0 0 0 0 1 0 0 0 0 0 0 0 0 000  1 3 1 1 0 0 0 0 0
3 1 1 1 0 0 0 0 0 0 0 0 0 0 1 0 0 000  1 4 1 1 1 1 0 A 0
3 1 1 1 0 0 1 0 0 0 0 0 0 0 0 0 0 000  1 5 1 1 1 0 0 1 0
3 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 000  0 0 1 1 1 0 0 0 0
4 1 1 1 0 0 0 1 0 0 0 0 0 0 0 0 0 000  0 0 1 1 1 3 0 0 0
4 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 000  0 0 1 1 0 3 0 0 0
4 1 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 000  0 0 1 1 0 3 0 0 0
4 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 000  0 0 1 1 0 1 0 0 0
4 0 1 1 0 0 0 1 0 0 0 0 0 0 0 0 0 000  0 0 1 1 1 3 0 0 0
4 0 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 000  0 0 1 1 0 3 0 0 0
4 0 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 000  0 0 1 1 0 3 0 0 0
4 0 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 000  0 0 0 0 0 3 0 0 0
4 0 1 1 0 0 0 0 0 0 0 0 0 0 1 0 0 000  0 0 0 0 0 3 0 0 0
4 0 1 0 0 0 0 0 0 0 0 0 0 0 1 0 0 000  1 4 1 1 0 0 0 C 0
4 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 000  0 0 1 1 0 0 0 0 0
4 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 000  0 0 1 1 1 0 0 0 0
5 1 1 1 0 0 0 0 0 0 0 0 0 0 0 6 0 000  0 0 1 1 1 2 0 0 0
5 1 1 1 0 0 0 0 0 0 0 0 0 0 0 6 0 000  0 0 1 1 0 2 1 0 0
5 1 1 1 0 0 0 0 0 0 0 0 0 0 0 2 0 000  0 0 1 1 0 2 0 0 0
5 1 1 1 0 0 0 0 0 0 0 0 0 0 0 3 0 000  1 7 1 1 0 2 0 0 0
5 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 000  0 0 1 1 0 2 0 0 0
5 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 000  0 0 1 1 1 0 0 0 0
5 1 1 1 0 0 0 0 0 0 3 0 0 0 0 6 0 000  0 0 1 1 1 2 0 0 0
5 1 1 1 0 0 0 0 1 0 0 0 0 0 0 6 0 000  1 3 1 1 0 2 0 0 0
5 1 1 1 0 0 0 0 0 0 0 0 0 0 0 6 0 000  0 0 1 1 0 2 1 0 0
5 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 000  0 0 1 1 0 2 0 0 0
5 1 1 0 0 0 0 0 0 0 0 0 0 1 0 6 0 000  0 0 1 1 1 2 0 0 0
5 1 1 1 0 0 0 0 0 0 0 0 0 0 0 6 0 000  0 0 1 1 0 2 1 0 0
5 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 000  0 0 1 1 0 2 0 0 0
5 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 000  0 0 1 1 1 0 0 0 0

/* compile.f */
hw/ctrl_pkg.sv
hw/ctrl_fsm.sv
hw/hazard_unit.sv
hw/fwd_unit.sv
hw/ctrl_top.sv
tests/ctrl_tb.sv

/* Bender.yml */
package:
  name: ctrl

sources:
  - hw/ctrl_pkg.sv
  - hw/ctrl_fsm.sv
  - hw/hazard_unit.sv
  - hw/fwd_unit.sv
  - hw/ctrl_top.sv
  - target: test
    files:
      - tests/ctrl_tb.sv
